/* verilog/pagerank_pkg.sv */
/*
  shared widths, host and memory codes,
  and the memory word union
*/
`default_nettype none

package pagerank_pkg;

  // --------------------------------------------------
  // datapath widths
  // --------------------------------------------------
  localparam int elem_bits = 8;
  localparam int lanes     = 4;
  localparam int word_bits = 32;

  // one memory word, seen whole or as byte lanes
  // lane 0 sits in the low byte
  typedef union packed {
    logic [word_bits-1:0]            word;
    logic [lanes-1:0][elem_bits-1:0] lane;
  } mem_word_t;

  // --------------------------------------------------
  // host register map and message types
  // --------------------------------------------------
  localparam logic [word_bits-1:0] host_addr_go     = 32'd0;
  localparam logic [word_bits-1:0] host_addr_base_g = 32'd1;
  localparam logic [word_bits-1:0] host_addr_base_r = 32'd2;
  localparam logic [word_bits-1:0] host_addr_size   = 32'd3;

  localparam logic host_rd = 1'b0;
  localparam logic host_wr = 1'b1;

  // memory request types
  localparam logic [2:0] mem_rd = 3'd0;
  localparam logic [2:0] mem_wr = 3'd1;

endpackage

`default_nettype wire

/* verilog/host_port.sv */
/*
  host request decode, config registers, same-cycle host response
*/
`timescale 1ns/1ps
`default_nettype none

module host_port (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               busy,
  input  logic                               pr_req_val,
  input  logic                               pr_req_type,
  input  logic [pagerank_pkg::word_bits-1:0] pr_req_addr,
  input  logic [pagerank_pkg::word_bits-1:0] pr_req_data,
  input  logic                               pr_resp_rdy,
  output logic                               pr_req_rdy,
  output logic                               pr_resp_val,
  output logic                               pr_resp_type,
  output logic [pagerank_pkg::word_bits-1:0] pr_resp_data,
  output logic                               start,
  output logic [pagerank_pkg::word_bits-1:0] base_g,
  output logic [pagerank_pkg::word_bits-1:0] base_r
);
  import pagerank_pkg::*;

  logic wr_go;

  // request and response pair up and stall while busy
  assign pr_req_rdy   = !busy && pr_resp_rdy;
  assign pr_resp_val  = !busy && pr_req_val;
  assign pr_resp_type = (pr_req_type == host_wr) ? host_wr : host_rd;
  assign pr_resp_data = (pr_req_type == host_wr) ? '0 : word_bits'(1);

  // accepted write
  assign wr_go = pr_req_val && pr_req_rdy && (pr_req_type == host_wr);
  assign start = wr_go && (pr_req_addr == host_addr_go);

  // --------------------------------------------------
  // config registers
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      base_g <= '0;
      base_r <= '0;
    end else if (wr_go) begin
      if (pr_req_addr == host_addr_base_g) base_g <= pr_req_data;
      if (pr_req_addr == host_addr_base_r) base_r <= pr_req_data;
    end
  end

endmodule

`default_nettype wire

/* verilog/scheduler_ctrl.sv */
/*
  run FSM for one rank update
  half and row counters, memory addressing, register strobes
*/
`timescale 1ns/1ps
`default_nettype none

module scheduler_ctrl #(
  parameter int rank_len = 8
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               start,
  input  logic [pagerank_pkg::word_bits-1:0] base_g,
  input  logic [pagerank_pkg::word_bits-1:0] base_r,
  input  logic                               mem_req_rdy,
  input  logic                               mem_resp_val,
  output logic                               busy,
  output logic                               mem_req_val,
  output logic [2:0]                         mem_req_type,
  output logic [pagerank_pkg::word_bits-1:0] mem_req_addr,
  output logic                               mem_resp_rdy,
  output logic                               old_load,
  output logic                               new_write,
  output logic                               accumulate,
  output logic                               g_load,
  output logic [((rank_len / pagerank_pkg::lanes > 1) ?
                 $clog2(rank_len / pagerank_pkg::lanes) : 1)-1:0] half,
  output logic [((rank_len > 1) ? $clog2(rank_len) : 1)-1:0]      row
);
  import pagerank_pkg::*;

  localparam int halves    = rank_len / lanes;
  localparam int half_bits = (halves > 1) ? $clog2(halves) : 1;
  localparam int row_bits  = (rank_len > 1) ? $clog2(rank_len) : 1;

  localparam logic [half_bits-1:0] last_half = half_bits'(halves - 1);
  localparam logic [row_bits-1:0]  last_row  = row_bits'(rank_len - 1);

  // state encoding
  localparam logic [2:0] idle           = 3'd0;
  localparam logic [2:0] read_rank      = 3'd1;
  localparam logic [2:0] wait_rank      = 3'd2;
  localparam logic [2:0] read_g         = 3'd3;
  localparam logic [2:0] wait_g         = 3'd4;
  localparam logic [2:0] accumulate_row = 3'd5;
  localparam logic [2:0] write_rank     = 3'd6;
  localparam logic [2:0] wait_write     = 3'd7;

  logic [2:0]           state;
  logic [2:0]           state_next;
  logic [half_bits-1:0] half_next;
  logic [row_bits-1:0]  row_next;
  logic                 req_go;
  logic                 resp_go;
  logic [word_bits-1:0] half_ofs;
  logic [word_bits-1:0] row_ofs;

  assign req_go  = mem_req_val && mem_req_rdy;
  assign resp_go = mem_resp_val && mem_resp_rdy;
  assign busy    = (state != idle);

  // --------------------------------------------------
  // byte addresses
  // --------------------------------------------------
  // half selects a word column, row strides a full G row
  assign half_ofs = word_bits'(half) * word_bits'(lanes);
  assign row_ofs  = word_bits'(row) * word_bits'(rank_len);

  assign mem_req_addr = (state == read_g) ? (base_g + row_ofs + half_ofs)
                                          : (base_r + half_ofs);
  assign mem_req_type = (state == write_rank) ? mem_wr : mem_rd;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      half  <= '0;
      row   <= '0;
    end else begin
      state <= state_next;
      half  <= half_next;
      row   <= row_next;
    end
  end

  // --------------------------------------------------
  // next state and strobes
  // --------------------------------------------------
  always_comb begin
    state_next   = state;
    half_next    = half;
    row_next     = row;
    mem_req_val  = 1'b0;
    mem_resp_rdy = 1'b0;
    old_load     = 1'b0;
    g_load       = 1'b0;
    new_write    = 1'b0;
    accumulate   = 1'b0;
    case (state)
      idle: begin
        if (start) begin
          state_next = read_rank;
          half_next  = '0;
          row_next   = '0;
        end
      end
      read_rank: begin
        mem_req_val = 1'b1;
        if (req_go) state_next = wait_rank;
      end
      wait_rank: begin
        mem_resp_rdy = 1'b1;
        // rank word lands in old lanes of this half
        old_load = resp_go;
        if (resp_go) state_next = read_g;
      end
      read_g: begin
        mem_req_val = 1'b1;
        if (req_go) state_next = wait_g;
      end
      wait_g: begin
        mem_resp_rdy = 1'b1;
        g_load       = resp_go;
        if (resp_go) state_next = accumulate_row;
      end
      accumulate_row: begin
        // first half overwrites, later halves add on
        new_write  = 1'b1;
        accumulate = (half != '0);
        if (row != last_row) begin
          row_next   = row + 1'b1;
          state_next = read_g;
        end else begin
          row_next = '0;
          if (half == last_half) begin
            half_next  = '0;
            state_next = write_rank;
          end else begin
            half_next  = half + 1'b1;
            state_next = read_rank;
          end
        end
      end
      write_rank: begin
        mem_req_val = 1'b1;
        if (req_go) state_next = wait_write;
      end
      wait_write: begin
        mem_resp_rdy = 1'b1;
        if (resp_go) begin
          if (half == last_half) begin
            half_next  = '0;
            state_next = idle;
          end else begin
            half_next  = half + 1'b1;
            state_next = write_rank;
          end
        end
      end
      default: state_next = idle;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/rank_vector_regs.sv */
/*
  old and new rank banks, lane loading and write-back word
*/
`timescale 1ns/1ps
`default_nettype none

module rank_vector_regs #(
  parameter int rank_len = 8
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [pagerank_pkg::word_bits-1:0] mem_resp_data,
  input  logic                               old_load,
  input  logic                               new_write,
  input  logic                               accumulate,
  input  logic [((rank_len / pagerank_pkg::lanes > 1) ?
                 $clog2(rank_len / pagerank_pkg::lanes) : 1)-1:0] half,
  input  logic [((rank_len > 1) ? $clog2(rank_len) : 1)-1:0]      row,
  input  logic [pagerank_pkg::elem_bits-1:0] lane_sum,
  output logic [pagerank_pkg::lanes-1:0][pagerank_pkg::elem_bits-1:0] old_lanes,
  output logic [pagerank_pkg::word_bits-1:0] wr_word
);
  import pagerank_pkg::*;

  logic [elem_bits-1:0] old_bank [rank_len];
  logic [elem_bits-1:0] new_bank [rank_len];
  mem_word_t            resp_w;
  mem_word_t            wr_w;

  assign resp_w.word = mem_resp_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < rank_len; i++) begin
        old_bank[i] <= '0;
        new_bank[i] <= '0;
      end
    end else begin
      // one rank word fills four old elements
      if (old_load) begin
        for (int b = 0; b < lanes; b++) old_bank[lanes * half + b] <= resp_w.lane[b];
      end
      // sums wrap modulo 256
      if (new_write) new_bank[row] <= accumulate ? new_bank[row] + lane_sum : lane_sum;
    end
  end

  // selected half, read back as lanes
  always_comb begin
    for (int b = 0; b < lanes; b++) begin
      old_lanes[b]  = old_bank[lanes * half + b];
      wr_w.lane[b]  = new_bank[lanes * half + b];
    end
  end

  assign wr_word = wr_w.word;

endmodule

`default_nettype wire

/* verilog/dot_product_unit.sv */
/*
  G word register and four-lane multiply-accumulate
*/
`timescale 1ns/1ps
`default_nettype none

module dot_product_unit (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               g_load,
  input  logic [pagerank_pkg::word_bits-1:0] mem_resp_data,
  input  logic [pagerank_pkg::lanes-1:0][pagerank_pkg::elem_bits-1:0] old_lanes,
  output logic [pagerank_pkg::elem_bits-1:0] lane_sum
);
  import pagerank_pkg::*;

  // one G word, G[row][4h+b] in lane b
  mem_word_t g_word;

  always_ff @(posedge clk) begin
    if (reset) g_word <= '0;
    else if (g_load) g_word.word <= mem_resp_data;
  end

  // products truncate to 8 bits, sum wraps too
  always_comb begin
    lane_sum = '0;
    for (int b = 0; b < lanes; b++) lane_sum = lane_sum + g_word.lane[b] * old_lanes[b];
  end

endmodule

`default_nettype wire

/* verilog/pagerank_scheduler.sv */
/*
  pagerank scheduler top level
  wires host port, controller, rank banks and dot product unit
*/
`timescale 1ns/1ps
`default_nettype none

module pagerank_scheduler #(
  parameter int rank_len = 8
) (
  input  logic                               clk,
  input  logic                               reset,

  // host request and response
  input  logic                               pr_req_val,
  output logic                               pr_req_rdy,
  input  logic                               pr_req_type,
  input  logic [pagerank_pkg::word_bits-1:0] pr_req_addr,
  input  logic [pagerank_pkg::word_bits-1:0] pr_req_data,
  output logic                               pr_resp_val,
  input  logic                               pr_resp_rdy,
  output logic                               pr_resp_type,
  output logic [pagerank_pkg::word_bits-1:0] pr_resp_data,

  // memory request and response
  output logic                               mem_req_val,
  input  logic                               mem_req_rdy,
  output logic [2:0]                         mem_req_type,
  output logic [pagerank_pkg::word_bits-1:0] mem_req_addr,
  output logic [pagerank_pkg::word_bits-1:0] mem_req_data,
  input  logic                               mem_resp_val,
  output logic                               mem_resp_rdy,
  input  logic [pagerank_pkg::word_bits-1:0] mem_resp_data
);
  import pagerank_pkg::*;

  localparam int halves    = rank_len / lanes;
  localparam int half_bits = (halves > 1) ? $clog2(halves) : 1;
  localparam int row_bits  = (rank_len > 1) ? $clog2(rank_len) : 1;

  // host port to controller
  logic                 busy;
  logic                 start;
  logic [word_bits-1:0] base_g;
  logic [word_bits-1:0] base_r;

  // controller strobes and indices
  logic                 old_load;
  logic                 new_write;
  logic                 accumulate;
  logic                 g_load;
  logic [half_bits-1:0] half;
  logic [row_bits-1:0]  row;

  // datapath
  logic [lanes-1:0][elem_bits-1:0] old_lanes;
  logic [elem_bits-1:0]            lane_sum;

  host_port u_host (
    .clk          (clk),
    .reset        (reset),
    .busy         (busy),
    .pr_req_val   (pr_req_val),
    .pr_req_type  (pr_req_type),
    .pr_req_addr  (pr_req_addr),
    .pr_req_data  (pr_req_data),
    .pr_resp_rdy  (pr_resp_rdy),
    .pr_req_rdy   (pr_req_rdy),
    .pr_resp_val  (pr_resp_val),
    .pr_resp_type (pr_resp_type),
    .pr_resp_data (pr_resp_data),
    .start        (start),
    .base_g       (base_g),
    .base_r       (base_r)
  );

  scheduler_ctrl #(.rank_len(rank_len)) u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .base_g       (base_g),
    .base_r       (base_r),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp_val (mem_resp_val),
    .busy         (busy),
    .mem_req_val  (mem_req_val),
    .mem_req_type (mem_req_type),
    .mem_req_addr (mem_req_addr),
    .mem_resp_rdy (mem_resp_rdy),
    .old_load     (old_load),
    .new_write    (new_write),
    .accumulate   (accumulate),
    .g_load       (g_load),
    .half         (half),
    .row          (row)
  );

  // write-back data is the new word of the current half
  rank_vector_regs #(.rank_len(rank_len)) u_ranks (
    .clk           (clk),
    .reset         (reset),
    .mem_resp_data (mem_resp_data),
    .old_load      (old_load),
    .new_write     (new_write),
    .accumulate    (accumulate),
    .half          (half),
    .row           (row),
    .lane_sum      (lane_sum),
    .old_lanes     (old_lanes),
    .wr_word       (mem_req_data)
  );

  dot_product_unit u_dot (
    .clk           (clk),
    .reset         (reset),
    .g_load        (g_load),
    .mem_resp_data (mem_resp_data),
    .old_lanes     (old_lanes),
    .lane_sum      (lane_sum)
  );

endmodule

`default_nettype wire

/* tests/tb_pagerank_scheduler.sv */
/*
  testbench for the pagerank scheduler
  case table, byte memory model with stalls, reference rank update
*/
`timescale 1ns/1ps
`default_nettype none

module tb_pagerank_scheduler;
  import pagerank_pkg::*;

  localparam int n_elem = 8;
  localparam int limit  = 1000;
  localparam int n_case = 4;

  logic        clk;
  logic        reset;
  logic        pr_req_val, pr_req_rdy, pr_req_type;
  logic [31:0] pr_req_addr, pr_req_data;
  logic        pr_resp_val, pr_resp_rdy, pr_resp_type;
  logic [31:0] pr_resp_data;
  logic        mem_req_val, mem_req_rdy;
  logic [2:0]  mem_req_type;
  logic [31:0] mem_req_addr, mem_req_data;
  logic        mem_resp_val, mem_resp_rdy;
  logic [31:0] mem_resp_data;

  // case table of G base, rank base, content seed and stall level
  logic [7:0]  case_bg    [n_case] = '{8'd0, 8'd96, 8'd128, 8'd8};
  logic [7:0]  case_br    [n_case] = '{8'd64, 8'd200, 8'd16, 8'd240};
  logic [31:0] case_seed  [n_case] = '{32'h1, 32'h5a5a0002, 32'h00c0ffee, 32'h13579bdf};
  int          case_stall [n_case] = '{0, 3, 5, 1};

  logic [7:0]  mem [256];
  logic [7:0]  exp_rank [n_elem];
  logic [31:0] rng;
  logic [31:0] wdata;
  int          errors, checks, case_errors;
  logic        timed_out;

  pagerank_scheduler #(.rank_len(n_elem)) DUT (.*);

  always #10 clk = ~clk;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (!timed_out) begin
      checks++;
      if (got !== exp) begin
        errors++;
        $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
    end
  endtask

  task automatic note_timeout(input string what);
    if (!timed_out) $display("timeout: no %s within %0d cycles", what, limit);
    timed_out = 1'b1;
  endtask

  // random wait of 0..level falling edges
  task automatic stall_cycles(input int level);
    int k;
    k = 0;
    if (level > 0) begin
      rng = lcg_next(rng);
      k = rng[15:8] % (level + 1);
    end
    repeat (k) @(negedge clk);
  endtask

  // new element j is the sum over k of G[j][k] * rank[k] mod 256
  function automatic logic [7:0] ref_elem(input logic [7:0] bg, input logic [7:0] br, input int j);
    logic [7:0] acc;
    logic [7:0] ga;
    acc = 8'd0;
    for (int k = 0; k < n_elem; k++) begin
      ga  = bg + 8'(n_elem * j + k);
      acc = acc + mem[ga] * mem[br + 8'(k)];
    end
    return acc;
  endfunction

  task automatic host_xfer(input logic typ, input logic [31:0] addr, input logic [31:0] data,
                           input logic exp_type, input logic [31:0] exp_data);
    int n;
    n = 0;
    pr_req_val  = 1'b1;
    pr_req_type = typ;
    pr_req_addr = addr;
    pr_req_data = data;
    // combinational response settles
    #1;
    while (!pr_req_rdy && !timed_out) begin
      @(negedge clk);
      n++;
      if (n > limit) note_timeout("host request ready");
    end
    // response must be there in the accepting cycle
    check(pr_resp_val, 1, "pr_resp_val");
    check(pr_resp_type, exp_type, "pr_resp_type");
    check(pr_resp_data, exp_data, "pr_resp_data");
    @(negedge clk);
    pr_req_val = 1'b0;
  endtask

  // one memory request and its response with address and type checked
  task automatic mem_xfer(input logic [31:0] exp_addr, input logic [2:0] exp_type,
                          input int level, output logic [31:0] data);
    int         n;
    logic [7:0] a;
    n = 0;
    while (!mem_req_val && !timed_out) begin
      check(pr_req_rdy, 0, "pr_req_rdy while busy");
      @(negedge clk);
      n++;
      if (n > limit) note_timeout("memory request");
    end
    stall_cycles(level);
    check(mem_req_addr, exp_addr, "mem_req_addr");
    check(32'(mem_req_type), 32'(exp_type), "mem_req_type");
    a    = mem_req_addr[7:0];
    data = mem_req_data;
    mem_req_rdy = 1'b1;
    @(negedge clk);
    mem_req_rdy = 1'b0;
    stall_cycles(level);
    if (exp_type == mem_wr) begin
      for (int b = 0; b < 4; b++) mem[a + 8'(b)] = data[8*b +: 8];
      mem_resp_data = 32'd0;
    end else begin
      mem_resp_data = {mem[a + 8'd3], mem[a + 8'd2], mem[a + 8'd1], mem[a]};
    end
    mem_resp_val = 1'b1;
    n = 0;
    while (!mem_resp_rdy && !timed_out) begin
      @(negedge clk);
      n++;
      if (n > limit) note_timeout("memory response ready");
    end
    @(negedge clk);
    mem_resp_val  = 1'b0;
    mem_resp_data = 32'd0;
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    int n;
    clk           = 1'b0;
    reset         = 1'b1;
    pr_req_val    = 1'b0;
    pr_req_type   = host_rd;
    pr_req_addr   = 32'd0;
    pr_req_data   = 32'd0;
    pr_resp_rdy   = 1'b1;
    mem_req_rdy   = 1'b0;
    mem_resp_val  = 1'b0;
    mem_resp_data = 32'd0;
    errors        = 0;
    checks        = 0;
    timed_out     = 1'b0;
    rng = 32'hc9b75f4c;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    check(pr_resp_val, 0, "pr_resp_val after reset");
    check(mem_req_val, 0, "mem_req_val after reset");
    check(mem_resp_rdy, 0, "mem_resp_rdy after reset");
    host_xfer(host_rd, 32'd0, 32'd0, host_rd, 32'd1);
    for (int c = 0; c < n_case; c++) begin
      case_errors = errors;
      // fill depends on every address bit and the case seed
      rng = 32'hc9b75f4c ^ case_seed[c];
      for (int a = 0; a < 256; a++) begin
        rng = lcg_next(rng);
        mem[a] = rng[23:16] ^ 8'(a);
      end
      for (int j = 0; j < n_elem; j++) exp_rank[j] = ref_elem(case_bg[c], case_br[c], j);
      host_xfer(host_wr, 32'(host_addr_base_g), 32'(case_bg[c]), host_wr, 32'd0);
      host_xfer(host_wr, 32'(host_addr_base_r), 32'(case_br[c]), host_wr, 32'd0);
      host_xfer(host_wr, 32'(host_addr_size), 32'(n_elem), host_wr, 32'd0);
      host_xfer(host_wr, 32'(host_addr_go), 32'd0, host_wr, 32'd0);
      // per half the rank word and then one G word per row
      for (int h = 0; h < n_elem / 4; h++) begin
        mem_xfer(32'(case_br[c]) + 32'(4 * h), mem_rd, case_stall[c], wdata);
        for (int j = 0; j < n_elem; j++)
          mem_xfer(32'(case_bg[c]) + 32'(n_elem * j + 4 * h), mem_rd, case_stall[c], wdata);
      end
      // write-back with element 4h+b in lane b of word h
      for (int h = 0; h < n_elem / 4; h++) begin
        mem_xfer(32'(case_br[c]) + 32'(4 * h), mem_wr, case_stall[c], wdata);
        check(wdata, {exp_rank[4*h+3], exp_rank[4*h+2], exp_rank[4*h+1], exp_rank[4*h]},
              "written rank word");
      end
      n = 0;
      while (!pr_req_rdy && !timed_out) begin
        @(negedge clk);
        n++;
        if (n > limit) note_timeout("return to idle");
      end
      $display("case %0d: base_g %0d base_r %0d stall %0d, %0d mismatches", c, case_bg[c],
               case_br[c], case_stall[c], errors - case_errors);
    end
    $display("%0d cases, %0d checks, %0d mismatches, timeout %0d", n_case, checks, errors,
             timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* pagerank_scheduler.f */
verilog/pagerank_pkg.sv
verilog/host_port.sv
verilog/scheduler_ctrl.sv
verilog/rank_vector_regs.sv
verilog/dot_product_unit.sv
verilog/pagerank_scheduler.sv
tests/tb_pagerank_scheduler.sv

/* Makefile */
# Verilator build and run of the pagerank scheduler testbench

TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_pagerank_scheduler
FILELIST = pagerank_scheduler.f

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
